// ==== verilog/glyph_table.svh ====
`ifndef GLYPH_TABLE_SVH
`define GLYPH_TABLE_SVH

// pawns point the way their side moves
function automatic glyph_kind_t kind_of(logic side, piece_idx_t index);
	glyph_kind_t kind;
	if (index[3]) begin
		kind = side ? GLYPH_PAWN_UP : GLYPH_PAWN_DOWN;
	end else begin
		case (index[2:1])
			2'd3: kind = GLYPH_ROOK;
			2'd2: kind = GLYPH_KNIGHT;
			2'd1: kind = GLYPH_BISHOP;
			default: kind = index[0] ? GLYPH_QUEEN : GLYPH_KING;
		endcase
	end
	return kind;
endfunction

// rows listed top first, bit 0 is the leftmost cell
function automatic logic [7:0] glyph_row(glyph_kind_t kind, logic [2:0] row);
	logic [63:0] rows;
	case (kind)
		GLYPH_PAWN_UP:
			rows = {8'b00000000, 8'b00011000, 8'b01011010, 8'b01000010,
				8'b00111100, 8'b00100100, 8'b00111100, 8'b00000000};
		GLYPH_PAWN_DOWN:
			rows = {8'b00000000, 8'b00111100, 8'b00100100, 8'b00111100,
				8'b01000010, 8'b01011010, 8'b00011000, 8'b00000000};
		GLYPH_ROOK:
			rows = {8'b00011000, 8'b00011000, 8'b00000000, 8'b11011011,
				8'b11011011, 8'b00000000, 8'b00011000, 8'b00011000};
		GLYPH_KNIGHT:
			rows = {8'b00000000, 8'b00100100, 8'b01000010, 8'b00011000,
				8'b00011000, 8'b01000010, 8'b00100100, 8'b00000000};
		GLYPH_BISHOP:
			rows = {8'b10000001, 8'b01000010, 8'b00100100, 8'b00011000,
				8'b00011000, 8'b00100100, 8'b01000010, 8'b10000001};
		GLYPH_QUEEN:
			rows = {8'b10011001, 8'b01011010, 8'b00100100, 8'b11011011,
				8'b11011011, 8'b00100100, 8'b01011010, 8'b10011001};
		GLYPH_KING:
			rows = {8'b00000000, 8'b01111110, 8'b01000010, 8'b01011010,
				8'b01011010, 8'b01000010, 8'b01111110, 8'b00000000};
		default:
			rows = '0;
	endcase
	return rows[(7 - row) * 8 +: 8];
endfunction

`endif

// ==== verilog/chess_lcd_pkg.sv ====
package chess_lcd_pkg;

	// 480x272 panel, totals include porches
	localparam int H_TOTAL = 526;
	localparam int V_TOTAL = 286;
	localparam int H_ACTIVE = 480;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 1;
	localparam int V_ACTIVE = 272;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);

	// a8 is the top left square
	localparam int BOARD_X = 108;
	localparam int BOARD_Y = 4;
	localparam int SQUARE_PX = 33;
	localparam int BORDER_PX = 4;
	localparam int CELL_PX = 4;

	localparam int PIPE_DEPTH = 3;

	localparam logic [23:0] COLOR_BORDER = 24'h00FE00;
	localparam logic [23:0] COLOR_LIGHT = 24'h6797CC;
	localparam logic [23:0] COLOR_DARK = 24'h11448B;
	localparam logic [23:0] COLOR_CURSOR = 24'h3A9972;
	localparam logic [23:0] COLOR_WHITE = 24'hFFFFFF;
	localparam logic [23:0] COLOR_BLACK = 24'h000000;

	// rank in [5:3], file in [2:0]
	typedef logic [5:0] square_t;
	// 0 king, 1 queen, 2-3 bishops, 4-5 knights, 6-7 rooks, 8-15 pawns
	typedef logic [3:0] piece_idx_t;

	typedef enum logic [2:0] {
		GLYPH_PAWN_UP,
		GLYPH_PAWN_DOWN,
		GLYPH_ROOK,
		GLYPH_KNIGHT,
		GLYPH_BISHOP,
		GLYPH_QUEEN,
		GLYPH_KING
	} glyph_kind_t;

	typedef struct packed {
		logic present;
		logic side;
		piece_idx_t index;
	} piece_hit_t;

	// black beats white, lower index beats higher
	function automatic piece_hit_t find_piece(square_t sq, logic [95:0] loc_w,
		logic [95:0] loc_b, logic [15:0] alive_w, logic [15:0] alive_b);
		piece_hit_t hit;
		hit = '0;
		for (int i = 15; i >= 0; i--) begin
			if (alive_w[i] && loc_w[i*6 +: 6] == sq) begin
				hit = '{present: 1'b1, side: 1'b1, index: piece_idx_t'(i)};
			end
		end
		for (int i = 15; i >= 0; i--) begin
			if (alive_b[i] && loc_b[i*6 +: 6] == sq) begin
				hit = '{present: 1'b1, side: 1'b0, index: piece_idx_t'(i)};
			end
		end
		return hit;
	endfunction

endpackage

// ==== verilog/board_pos_if.sv ====
`timescale 1ns/1ps

interface board_pos_if;
	logic [2:0] rank;
	logic [2:0] file;
	logic in_board;
	logic on_border;
	// offset inside the square, 0 to 32
	logic [5:0] sub_x;
	logic [5:0] sub_y;
	logic line_active;

	modport source (output rank, file, in_board, on_border, sub_x, sub_y, line_active);
	modport sink (input rank, file, in_board, on_border, sub_x, sub_y, line_active);
endinterface

// ==== verilog/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing #(
	parameter int H_TOTAL = 526,
	parameter int V_TOTAL = 286,
	parameter int H_SYNC_AT = 483,
	parameter int V_SYNC_AT = 274,
	parameter int PIPE_DEPTH = 3
) (
	input logic clk12,
	input logic reset,
	output logic [$clog2(H_TOTAL)-1:0] h_count,
	output logic [$clog2(V_TOTAL)-1:0] v_count,
	output logic hsync,
	output logic vsync,
	output logic disp
);

	// {disp, vsync, hsync} per pipeline stage
	logic [2:0] ctl_pipe [PIPE_DEPTH];

	always_ff @(posedge clk12) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == H_TOTAL - 1) begin
			h_count <= '0;
			if (v_count == V_TOTAL - 1) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// one-count sync windows, delayed to line up with bgr
	always_ff @(posedge clk12) begin
		if (reset) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				ctl_pipe[i] <= '0;
			end
		end else begin
			ctl_pipe[0] <= {1'b1, (v_count == V_SYNC_AT), (h_count == H_SYNC_AT)};
			for (int i = 1; i < PIPE_DEPTH; i++) begin
				ctl_pipe[i] <= ctl_pipe[i - 1];
			end
		end
	end

	assign hsync = ctl_pipe[PIPE_DEPTH - 1][0];
	assign vsync = ctl_pipe[PIPE_DEPTH - 1][1];
	assign disp = ctl_pipe[PIPE_DEPTH - 1][2];

endmodule

// ==== verilog/board_scan.sv ====
`timescale 1ns/1ps

module board_scan
	import chess_lcd_pkg::*;
#(
	parameter int BOARD_X = 108,
	parameter int BOARD_Y = 4,
	parameter int SQUARE_PX = 33,
	parameter int BORDER_PX = 4
) (
	input logic clk12,
	input logic [H_CNT_W-1:0] h_count,
	input logic [V_CNT_W-1:0] v_count,
	board_pos_if.source pos
);

	localparam int BOARD_PX = 8 * SQUARE_PX;

	int dx;
	int dy;
	logic in_board;
	logic in_frame;

	always_comb begin
		dx = int'(h_count) - BOARD_X;
		dy = int'(v_count) - BOARD_Y;
		in_board = dx >= 0 && dx < BOARD_PX && dy >= 0 && dy < BOARD_PX;
		// board plus its border ring
		in_frame = dx >= -BORDER_PX && dx < BOARD_PX + BORDER_PX &&
			dy >= -BORDER_PX && dy < BOARD_PX + BORDER_PX;
	end

	always_ff @(posedge clk12) begin
		pos.line_active <= h_count < H_ACTIVE && v_count < V_ACTIVE;
		pos.in_board <= in_board;
		pos.on_border <= in_frame && !in_board;
		if (in_board) begin
			pos.file <= 3'(dx / SQUARE_PX);
			// rank 7 at the top
			pos.rank <= 3'(7 - dy / SQUARE_PX);
			pos.sub_x <= 6'(dx % SQUARE_PX);
			pos.sub_y <= 6'(dy % SQUARE_PX);
		end else begin
			pos.file <= '0;
			pos.rank <= '0;
			pos.sub_x <= '0;
			pos.sub_y <= '0;
		end
	end

endmodule

// ==== verilog/piece_occupancy.sv ====
`timescale 1ns/1ps

module piece_occupancy
	import chess_lcd_pkg::*;
(
	input logic clk12,
	input logic [95:0] loc_white,
	input logic [95:0] loc_black,
	input logic [15:0] alive_white,
	input logic [15:0] alive_black,
	board_pos_if.sink pos_in,
	board_pos_if.source pos_out,
	output piece_hit_t hit
);

	piece_hit_t found;

	assign found = find_piece({pos_in.rank, pos_in.file}, loc_white, loc_black,
		alive_white, alive_black);

	always_ff @(posedge clk12) begin
		pos_out.rank <= pos_in.rank;
		pos_out.file <= pos_in.file;
		pos_out.in_board <= pos_in.in_board;
		pos_out.on_border <= pos_in.on_border;
		pos_out.sub_x <= pos_in.sub_x;
		pos_out.sub_y <= pos_in.sub_y;
		pos_out.line_active <= pos_in.line_active;
		// off-board pixels read as a1, keep them clear of its piece
		hit <= pos_in.in_board ? found : '0;
	end

endmodule

// ==== verilog/pixel_shader.sv ====
`timescale 1ns/1ps

module pixel_shader
	import chess_lcd_pkg::*;
(
	input logic clk12,
	input logic reset,
	board_pos_if.sink pos,
	input piece_hit_t hit,
	input square_t cursor,
	input logic player,
	output logic [23:0] bgr
);

	`include "glyph_table.svh"

	logic [7:0] glyph_bits;
	logic in_glyph;
	logic glyph_on;
	logic [23:0] color;

	assign glyph_bits = glyph_row(kind_of(hit.side, hit.index), 3'(pos.sub_y / CELL_PX));
	// last row and column of a square stay clear
	assign in_glyph = pos.sub_x < 8 * CELL_PX && pos.sub_y < 8 * CELL_PX;
	assign glyph_on = hit.present && in_glyph && glyph_bits[3'(pos.sub_x / CELL_PX)];

	// later assignments win
	always_comb begin
		color = player ? COLOR_WHITE : COLOR_BLACK;
		if (pos.on_border) begin
			color = COLOR_BORDER;
		end
		if (pos.in_board) begin
			color = (pos.rank[0] ^ pos.file[0]) ? COLOR_LIGHT : COLOR_DARK;
			if ({pos.rank, pos.file} == cursor) begin
				color = COLOR_CURSOR;
			end
			if (glyph_on) begin
				color = hit.side ? COLOR_WHITE : COLOR_BLACK;
			end
		end
		// blanking interval
		if (!pos.line_active) begin
			color = COLOR_BLACK;
		end
	end

	always_ff @(posedge clk12) begin
		if (reset) begin
			bgr <= COLOR_BLACK;
		end else begin
			bgr <= color;
		end
	end

endmodule

// ==== verilog/piece_finder.sv ====
`timescale 1ns/1ps

module piece_finder
	import chess_lcd_pkg::*;
(
	input logic clk12,
	input logic reset,
	input logic enter_pressed,
	input logic confirm_pressed,
	input square_t cursor,
	input logic [95:0] loc_white,
	input logic [95:0] loc_black,
	input logic [15:0] alive_white,
	input logic [15:0] alive_black,
	output piece_idx_t pid,
	output logic found_piece
);

	logic enter_d;
	logic enter_prev;
	logic confirm_d;
	logic lookup;
	piece_hit_t found;

	// index is 0 when nothing matches
	assign found = find_piece(cursor, loc_white, loc_black, alive_white, alive_black);

	always_ff @(posedge clk12) begin
		if (reset) begin
			enter_d <= 1'b0;
			enter_prev <= 1'b0;
			confirm_d <= 1'b0;
			lookup <= 1'b0;
			pid <= '0;
			found_piece <= 1'b0;
		end else begin
			enter_d <= enter_pressed;
			enter_prev <= enter_d;
			confirm_d <= confirm_pressed;
			// enter edge, ignored while confirm is held
			lookup <= enter_d && !enter_prev && !confirm_d;
			if (lookup) begin
				found_piece <= found.present;
				pid <= found.index;
			end
		end
	end

endmodule

// ==== verilog/chess_lcd_top.sv ====
`timescale 1ns/1ps

module chess_lcd_top
	import chess_lcd_pkg::*;
(
	input logic clk12,
	input logic reset,
	input logic [5:0] cursor,
	input logic player,
	input logic enter_pressed,
	input logic confirm_pressed,
	input logic [95:0] lvw,
	input logic [95:0] lvb,
	input logic [15:0] avw,
	input logic [15:0] avb,
	output logic [23:0] bgr,
	output logic hsync,
	output logic vsync,
	output logic disp,
	output logic [3:0] pid,
	output logic found_piece
);

	logic [H_CNT_W-1:0] h_count;
	logic [V_CNT_W-1:0] v_count;
	piece_hit_t hit;

	board_pos_if pos_s1 ();
	board_pos_if pos_s2 ();

	lcd_timing #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL),
		.H_SYNC_AT(H_ACTIVE + H_FRONT + H_SYNC),
		.V_SYNC_AT(V_ACTIVE + V_FRONT + V_SYNC),
		.PIPE_DEPTH(PIPE_DEPTH)
	) i_lcd_timing (
		.clk12(clk12),
		.reset(reset),
		.h_count(h_count),
		.v_count(v_count),
		.hsync(hsync),
		.vsync(vsync),
		.disp(disp)
	);

	board_scan #(
		.BOARD_X(BOARD_X),
		.BOARD_Y(BOARD_Y),
		.SQUARE_PX(SQUARE_PX),
		.BORDER_PX(BORDER_PX)
	) i_board_scan (
		.clk12(clk12),
		.h_count(h_count),
		.v_count(v_count),
		.pos(pos_s1)
	);

	piece_occupancy i_piece_occupancy (
		.clk12(clk12),
		.loc_white(lvw),
		.loc_black(lvb),
		.alive_white(avw),
		.alive_black(avb),
		.pos_in(pos_s1),
		.pos_out(pos_s2),
		.hit(hit)
	);

	pixel_shader i_pixel_shader (
		.clk12(clk12),
		.reset(reset),
		.pos(pos_s2),
		.hit(hit),
		.cursor(cursor),
		.player(player),
		.bgr(bgr)
	);

	piece_finder i_piece_finder (
		.clk12(clk12),
		.reset(reset),
		.enter_pressed(enter_pressed),
		.confirm_pressed(confirm_pressed),
		.cursor(cursor),
		.loc_white(lvw),
		.loc_black(lvb),
		.alive_white(avw),
		.alive_black(avb),
		.pid(pid),
		.found_piece(found_piece)
	);

endmodule

// ==== tests/chess_lcd_chk.sv ====
`timescale 1ns/1ps

module chess_lcd_chk
	import chess_lcd_pkg::*;
(
	input logic clk12,
	input logic reset,
	input logic hsync,
	input logic vsync,
	input logic disp
);

	// length of the current vsync pulse so far
	int vs_len;

	always_ff @(posedge clk12) begin
		if (reset || !vsync) begin
			vs_len <= 0;
		end else begin
			vs_len <= vs_len + 1;
		end
	end

	hsync_one_cycle: assert property (@(posedge clk12) disable iff (reset)
		$rose(hsync) |=> !hsync)
		else $error("hsync stayed high for more than one cycle");

	vsync_one_line: assert property (@(posedge clk12) disable iff (reset)
		$fell(vsync) |-> vs_len == H_TOTAL)
		else $error("vsync pulse lasted %0d cycles instead of one line", vs_len);

	disp_stays_high: assert property (@(posedge clk12) disable iff (reset) !$fell(disp))
		else $error("disp fell after it had risen");

endmodule

bind chess_lcd_top chess_lcd_chk i_chess_lcd_chk (
	.clk12(clk12),
	.reset(reset),
	.hsync(hsync),
	.vsync(vsync),
	.disp(disp)
);

// ==== tests/chess_lcd_tb.sv ====
`timescale 1ns/1ps

module chess_lcd_tb
	import chess_lcd_pkg::*;
();

	// guard already set by the shader's copy
	`undef GLYPH_TABLE_SVH
	`include "glyph_table.svh"

	localparam int H_SYNC_COL = 483;
	localparam int VS_FALL_LINE = 275;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int HS = 0;
	localparam int VS = 1;

	logic clk12;
	logic reset;
	logic [5:0] cursor;
	logic player;
	logic enter_pressed;
	logic confirm_pressed;
	logic [95:0] lvw;
	logic [95:0] lvb;
	logic [15:0] avw;
	logic [15:0] avb;
	logic [23:0] bgr;
	logic hsync;
	logic vsync;
	logic disp;
	logic [3:0] pid;
	logic found_piece;

	logic [23:0] frame [V_ACTIVE][H_ACTIVE];
	logic [31:0] rng_state;
	logic verdict_printed;

	chess_lcd_top i_chess_lcd_top (.*);

	initial begin
		clk12 = 1'b0;
		forever begin
			#20 clk12 = ~clk12;
		end
	end

	task automatic stop_run();
		verdict_printed = 1'b1;
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_value(string test, logic [31:0] expected, logic [31:0] actual);
		$display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
		stop_run();
	endtask

	task automatic report_problem(string what);
		$display("%s", what);
		stop_run();
	endtask

	function automatic logic sync_level(int which);
		return (which == HS) ? hsync : vsync;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// black first, then lowest index
	function automatic piece_hit_t piece_at(logic [5:0] sq);
		piece_hit_t h;
		h = '0;
		for (int i = 0; i < 16; i++) begin
			if (!h.present && avb[i] && lvb[i*6 +: 6] == sq) begin
				h = '{present: 1'b1, side: 1'b0, index: 4'(i)};
			end
		end
		for (int i = 0; i < 16; i++) begin
			if (!h.present && avw[i] && lvw[i*6 +: 6] == sq) begin
				h = '{present: 1'b1, side: 1'b1, index: 4'(i)};
			end
		end
		return h;
	endfunction

	function automatic logic [23:0] expected_pixel(int col, int line);
		int dx;
		int dy;
		logic [2:0] rank;
		logic [2:0] file;
		piece_hit_t h;
		logic [7:0] bits;
		logic [23:0] color;
		dx = col - BOARD_X;
		dy = line - BOARD_Y;
		color = player ? COLOR_WHITE : COLOR_BLACK;
		if ((col >= 104 && col <= 375 && (line <= 3 || (line >= 268 && line <= 271))) ||
			(line >= 4 && line <= 267 &&
			((col >= 104 && col <= 107) || (col >= 372 && col <= 375)))) begin
			color = COLOR_BORDER;
		end
		if (dx >= 0 && dx < 8 * SQUARE_PX && dy >= 0 && dy < 8 * SQUARE_PX) begin
			file = 3'(dx / SQUARE_PX);
			rank = 3'(7 - dy / SQUARE_PX);
			color = ((int'(rank) + int'(file)) % 2 == 0) ? COLOR_DARK : COLOR_LIGHT;
			if ({rank, file} == cursor) begin
				color = COLOR_CURSOR;
			end
			h = piece_at({rank, file});
			if (h.present && dx % SQUARE_PX < 32 && dy % SQUARE_PX < 32) begin
				bits = glyph_row(kind_of(h.side, h.index), 3'((dy % SQUARE_PX) / CELL_PX));
				if (bits[(dx % SQUARE_PX) / CELL_PX]) begin
					color = h.side ? COLOR_WHITE : COLOR_BLACK;
				end
			end
		end
		return color;
	endfunction

	task automatic wait_edge(input int which, input logic level, input int limit,
		output int cycles);
		logic prev;
		logic now;
		logic done;
		cycles = 0;
		done = 1'b0;
		prev = sync_level(which);
		while (!done) begin
			@(negedge clk12);
			cycles++;
			now = sync_level(which);
			done = (now == level) && (prev != level);
			prev = now;
			if (!done && cycles >= limit) begin
				report_problem($sformatf("timeout: %s did not go %0b within %0d cycles",
					(which == HS) ? "hsync" : "vsync", level, limit));
			end
		end
	endtask

	// starts on column 0 of line 275, right after the vsync fall
	task automatic capture_frame();
		int cycles;
		int line;
		wait_edge(VS, 1'b0, 2 * FRAME_CYCLES, cycles);
		for (int k = 0; k < V_TOTAL - (VS_FALL_LINE - V_ACTIVE); k++) begin
			line = (VS_FALL_LINE + k) % V_TOTAL;
			for (int col = 0; col < H_TOTAL; col++) begin
				assert (hsync == (col == H_SYNC_COL) && !vsync && disp)
					else report_problem($sformatf("sync or disp wrong at column %0d, line %0d",
						col, line));
				if (line < V_ACTIVE && col < H_ACTIVE) begin
					frame[line][col] = bgr;
				end
				@(negedge clk12);
			end
		end
	endtask

	task automatic compare_frame(string test);
		for (int y = 0; y < V_ACTIVE; y++) begin
			for (int x = 0; x < H_ACTIVE; x++) begin
				assert (frame[y][x] == expected_pixel(x, y))
					else report_value($sformatf("%s at (%0d,%0d)", test, x, y),
						expected_pixel(x, y), frame[y][x]);
			end
		end
	endtask

	task automatic check_pixel(string test, int col, int line, logic [23:0] expected);
		assert (frame[line][col] == expected)
			else report_value(test, expected, frame[line][col]);
	endtask

	// outputs must hold for two cycles, then show the lookup
	task automatic press_enter(string test, logic confirm, logic exp_found,
		logic [3:0] exp_pid);
		logic old_found;
		logic [3:0] old_pid;
		old_found = found_piece;
		old_pid = pid;
		confirm_pressed = confirm;
		enter_pressed = 1'b1;
		repeat (2) begin
			@(negedge clk12);
			assert (found_piece == old_found && pid == old_pid)
				else report_problem({test, ": finder outputs changed before the lookup cycle"});
		end
		@(negedge clk12);
		enter_pressed = 1'b0;
		assert ({found_piece, pid} == {exp_found, exp_pid})
			else report_value(test, {exp_found, exp_pid}, {found_piece, pid});
		repeat (2) @(negedge clk12);
		confirm_pressed = 1'b0;
	endtask

	task automatic reset_and_enable();
		int n;
		repeat (3) begin
			@(negedge clk12);
			assert (!disp && !hsync && !vsync && !found_piece && pid == 4'd0)
				else report_problem("outputs not cleared while reset is high");
		end
		reset = 1'b0;
		n = 0;
		while (!disp) begin
			@(negedge clk12);
			n++;
			if (!disp && n >= 10) begin
				report_problem("timeout: disp never rose after reset");
			end
		end
		assert (n == PIPE_DEPTH) else report_value("disp after reset", PIPE_DEPTH, n);
	endtask

	task automatic sync_periods();
		int cycles;
		wait_edge(HS, 1'b1, 2 * H_TOTAL, cycles);
		wait_edge(HS, 1'b1, 2 * H_TOTAL, cycles);
		assert (cycles == H_TOTAL) else report_value("hsync period", H_TOTAL, cycles);
		wait_edge(VS, 1'b1, 2 * FRAME_CYCLES, cycles);
		wait_edge(VS, 1'b1, 2 * FRAME_CYCLES, cycles);
		assert (cycles == FRAME_CYCLES) else report_value("vsync period", FRAME_CYCLES, cycles);
	endtask

	task automatic plain_board();
		cursor = 6'o77;
		player = 1'b1;
		capture_frame();
		compare_frame("plain board, player 1");
		check_pixel("border line 2", 200, 2, COLOR_BORDER);
		check_pixel("border column 105", 105, 100, COLOR_BORDER);
		check_pixel("light a8", 124, 20, COLOR_LIGHT);
		check_pixel("dark b8", 157, 20, COLOR_DARK);
		check_pixel("dark a1", 124, 251, COLOR_DARK);
		check_pixel("background player 1", 50, 100, COLOR_WHITE);
		player = 1'b0;
		capture_frame();
		compare_frame("plain board, player 0");
		check_pixel("background player 0", 50, 100, COLOR_BLACK);
	endtask

	task automatic cursor_highlight();
		cursor = 6'o32;
		player = 1'b1;
		capture_frame();
		compare_frame("cursor on c4");
		check_pixel("cursor c4 corner", 174, 136, COLOR_CURSOR);
		check_pixel("cursor c4 last column", 206, 168, COLOR_CURSOR);
		check_pixel("neighbour d4", 223, 152, COLOR_DARK);
	endtask

	task automatic piece_glyphs();
		// white king on e1, black pawn on d7
		lvw[0 +: 6] = 6'o04;
		avw[0] = 1'b1;
		lvb[8*6 +: 6] = 6'o63;
		avb[8] = 1'b1;
		cursor = 6'o04;
		capture_frame();
		compare_frame("glyphs");
		check_pixel("king glyph on", 245, 240, COLOR_WHITE);
		check_pixel("king glyph off", 241, 236, COLOR_CURSOR);
		check_pixel("pawn glyph on", 216, 42, COLOR_BLACK);
	endtask

	task automatic finder_lookups();
		cursor = 6'o04;
		press_enter("finder king e1", 1'b0, 1'b1, 4'd0);
		cursor = 6'o63;
		press_enter("finder confirm held", 1'b1, 1'b1, 4'd0);
		press_enter("finder pawn d7", 1'b0, 1'b1, 4'd8);
		cursor = 6'o30;
		press_enter("finder empty a4", 1'b0, 1'b0, 4'd0);
	endtask

	task automatic random_lookups();
		logic [31:0] r;
		piece_hit_t h;
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			lvw[i*6 +: 6] = r[31:26];
			lvb[i*6 +: 6] = r[25:20];
			avw[i] = r[19];
			avb[i] = r[18];
		end
		for (int n = 0; n < 10; n++) begin
			r = next_random();
			// half the cursors land where a white piece was placed
			cursor = r[31] ? lvw[int'(r[27:24]) * 6 +: 6] : r[21:16];
			h = piece_at(cursor);
			press_enter($sformatf("random cursor %0d", n), 1'b0, h.present, h.index);
		end
	endtask

	initial begin
		reset = 1'b1;
		cursor = '0;
		player = 1'b1;
		enter_pressed = 1'b0;
		confirm_pressed = 1'b0;
		lvw = '0;
		lvb = '0;
		avw = '0;
		avb = '0;
		rng_state = 32'hcc02_dbea;
		verdict_printed = 1'b0;
		reset_and_enable();
		sync_periods();
		plain_board();
		cursor_highlight();
		piece_glyphs();
		finder_lookups();
		random_lookups();
		verdict_printed = 1'b1;
		$display("TESTS PASSED");
		$finish;
	end

	// run ended by a bound assertion
	final begin
		if (!verdict_printed) begin
			$display("TESTS FAILED");
		end
	end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/chess_lcd_pkg.sv
verilog/board_pos_if.sv
verilog/lcd_timing.sv
verilog/board_scan.sv
verilog/piece_occupancy.sv
verilog/pixel_shader.sv
verilog/piece_finder.sv
verilog/chess_lcd_top.sv
tests/chess_lcd_chk.sv
tests/chess_lcd_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= chess_lcd_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= build.f
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
